// ==== design/icache_ctrl.sv ====
/*
 * Lookup and refill controller of the instruction cache.
 * Accepts one core request at a time, checks the tag array,
 * returns the word from the data array on a hit, or fetches the
 * line from the next level on a miss and writes both arrays.
 * Also emits one-cycle event pulses for the statistics block.
 */

`timescale 1ns/1ps

module icache_ctrl #(
  parameter int LINES = 64
) (
  input  logic                                      clk,
  input  logic                                      rstn,
  // Core side
  input  logic                                      core_req,
  input  logic [icache_pkg::ADDR_W-1:0]             core_addr,
  output logic                                      core_wait,
  output logic [icache_pkg::WORD_W-1:0]             core_rdata,
  // Next level
  output logic                                      mem_req,
  output logic [icache_pkg::ADDR_W-1:0]             mem_addr,
  input  logic                                      mem_valid,
  input  logic [icache_pkg::WORD_W-1:0]             mem_rdata,
  // Arrays
  output logic [$clog2(LINES)-1:0]                  ram_index,
  output logic                                      tag_re,
  output logic                                      tag_we,
  output logic [icache_pkg::ADDR_W-$clog2(LINES)-icache_pkg::OFFSET_W-1:0] tag_wdata,
  input  logic [icache_pkg::ADDR_W-$clog2(LINES)-icache_pkg::OFFSET_W-1:0] tag_rdata,
  output logic                                      data_re,
  output logic                                      data_we,
  output logic [icache_pkg::LINE_W-1:0]             data_wdata,
  input  logic [icache_pkg::LINE_W-1:0]             data_rdata,
  // Statistics events
  output logic                                      req_seen,
  output logic                                      hit_seen,
  output logic                                      fill_seen
);

  localparam int INDEX_W = $clog2(LINES);
  localparam int TAG_W   = icache_pkg::ADDR_W - INDEX_W - icache_pkg::OFFSET_W;
  localparam int BYTE_W  = $clog2(icache_pkg::WORD_W / 8);
  localparam int SEL_W   = icache_pkg::OFFSET_W - BYTE_W;
  localparam int CNT_W   = $clog2(icache_pkg::WORDS_PER_LINE) + 1;

  icache_pkg::icache_state_t state, next_state;

  logic [icache_pkg::ADDR_W-1:0] addr_r;
  logic [LINES-1:0]              valid;
  logic [CNT_W-1:0]              word_cnt;
  logic [icache_pkg::LINE_W-1:0] line_buf;
  logic                          hit_pend;

  logic                          accept;
  logic                          hit;
  logic                          fill_done;
  logic [INDEX_W-1:0]            in_index;
  logic [INDEX_W-1:0]            index_r;
  logic [TAG_W-1:0]              tag_r;
  logic [SEL_W-1:0]              word_sel;
  logic [icache_pkg::LINE_W-1:0] src_line;
  logic [icache_pkg::WORD_W-1:0] sel_word;

  // Address fields
  assign in_index = core_addr[icache_pkg::OFFSET_W +: INDEX_W];
  assign index_r  = addr_r[icache_pkg::OFFSET_W +: INDEX_W];
  assign tag_r    = addr_r[icache_pkg::ADDR_W-1 -: TAG_W];
  assign word_sel = addr_r[BYTE_W +: SEL_W];

  assign accept    = (state == icache_pkg::IDLE) && core_req && !core_wait;
  assign hit       = (tag_rdata == tag_r);
  assign fill_done = (state == icache_pkg::FILL) &&
                     (word_cnt == CNT_W'(icache_pkg::WORDS_PER_LINE));

  // ========================================
  // State machine
  // ========================================

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      state <= icache_pkg::IDLE;
    end else begin
      state <= next_state;
    end
  end

  always_comb begin
    next_state = state;
    case (state)
      icache_pkg::IDLE: begin
        if (accept) begin
          // Invalid line cannot hit, skip the compare
          next_state = valid[in_index] ? icache_pkg::LOOKUP : icache_pkg::FILL;
        end
      end
      icache_pkg::LOOKUP: next_state = hit ? icache_pkg::IDLE : icache_pkg::FILL;
      icache_pkg::FILL:   next_state = fill_done ? icache_pkg::IDLE : icache_pkg::FILL;
      default:            next_state = icache_pkg::IDLE;
    endcase
  end

  // Request address, sampled in the accepting cycle
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      addr_r <= '0;
    end else if (accept) begin
      addr_r <= core_addr;
    end
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      valid <= '0;
    end else if (fill_done) begin
      valid[index_r] <= 1'b1;
    end
  end

  // ========================================
  // Refill
  // ========================================

  // One pulse on entry to FILL
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      mem_req <= 1'b0;
    end else begin
      mem_req <= (state != icache_pkg::FILL) && (next_state == icache_pkg::FILL);
    end
  end

  assign mem_addr = {addr_r[icache_pkg::ADDR_W-1:icache_pkg::OFFSET_W],
                     {icache_pkg::OFFSET_W{1'b0}}};

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      word_cnt <= '0;
    end else if (fill_done) begin
      word_cnt <= '0;
    end else if (mem_valid) begin
      word_cnt <= word_cnt + 1'b1;
    end
  end

  // Words enter at the top, first word lands in the low slot
  always_ff @(posedge clk) begin
    if (mem_valid) begin
      line_buf <= {mem_rdata, line_buf[icache_pkg::LINE_W-1:icache_pkg::WORD_W]};
    end
  end

  // ========================================
  // Arrays and core response
  // ========================================

  assign ram_index  = (state == icache_pkg::IDLE) ? in_index : index_r;
  assign tag_re     = accept;
  assign tag_we     = fill_done;
  assign tag_wdata  = tag_r;
  assign data_re    = (state == icache_pkg::LOOKUP) && hit;
  assign data_we    = fill_done;
  assign data_wdata = line_buf;

  // Data array output arrives the cycle after the hit
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      hit_pend <= 1'b0;
    end else begin
      hit_pend <= data_re;
    end
  end

  assign src_line = hit_pend ? data_rdata : line_buf;
  assign sel_word = src_line[word_sel * icache_pkg::WORD_W +: icache_pkg::WORD_W];

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      core_wait  <= 1'b0;
      core_rdata <= '0;
    end else if (hit_pend || fill_done) begin
      core_wait  <= 1'b0;
      core_rdata <= sel_word;
    end else if (accept) begin
      core_wait  <= 1'b1;
    end
  end

  assign req_seen  = accept;
  assign hit_seen  = data_re;
  assign fill_seen = fill_done;

  // ========================================
  // Checks
  // ========================================

  a_mem_req_in_fill : assert property (
    @(posedge clk) disable iff (!rstn)
    mem_req |-> (state == icache_pkg::FILL) ##1 !mem_req
  ) else $error("icache_ctrl: mem_req outside FILL or longer than one cycle");

  a_mem_valid_in_fill : assert property (
    @(posedge clk) disable iff (!rstn)
    mem_valid |-> (state == icache_pkg::FILL)
  ) else $error("icache_ctrl: mem_valid without an open refill");

endmodule

// ==== design/icache_pkg.sv ====
/*
 * Shared definitions for the level-1 instruction cache.
 * Address and word widths, line geometry, the controller state
 * encoding and the statistics counter width. Modules reference
 * these by scoped name.
 */

package icache_pkg;

  // ========================================
  // Bus widths
  // ========================================

  // Core and next-level byte address
  localparam int ADDR_W = 32;

  // One instruction word
  localparam int WORD_W = 32;

  // ========================================
  // Line geometry
  // ========================================

  localparam int WORDS_PER_LINE = 4;
  localparam int LINE_W = WORDS_PER_LINE * WORD_W;

  // Byte offset inside a line, word select sits above the byte bits
  localparam int OFFSET_W = 4;

  // ========================================
  // Controller
  // ========================================

  typedef enum logic [1:0] {
    IDLE   = 2'd0,
    LOOKUP = 2'd1,
    FILL   = 2'd2
  } icache_state_t;

  // Statistics counters
  localparam int CNT_W = 32;

endpackage

// ==== design/icache_sram.sv ====
/*
 * Behavioral single-port synchronous SRAM.
 * Registered read one cycle after re, synchronous write on we.
 * The entry type is a parameter, so the same block holds either
 * the tag array or the line data array. Contents are not reset.
 */

`timescale 1ns/1ps

module icache_sram #(
  parameter type entry_t = logic [31:0],
  parameter int  DEPTH   = 64
) (
  input  logic                     clk,
  input  logic [$clog2(DEPTH)-1:0] index,
  input  logic                     re,
  input  logic                     we,
  input  entry_t                   wdata,
  output entry_t                   rdata
);

  entry_t mem [DEPTH];

  // Write port
  always_ff @(posedge clk) begin
    if (we) begin
      mem[index] <= wdata;
    end
  end

  // Read port, output holds while re is low
  always_ff @(posedge clk) begin
    if (re) begin
      rdata <= mem[index];
    end
  end

  // ========================================
  // Checks
  // ========================================

  // Controller never reads and writes the same array in one cycle
  a_no_rw_collision : assert property (
    @(posedge clk) !(re && we)
  ) else $error("icache_sram: read and write enabled together");

endmodule

// ==== design/icache_stats.sv ====
/*
 * Access statistics of the instruction cache.
 * Counts requests, hits and refills from one-cycle event pulses
 * of the controller. Counters saturate at all ones and update the
 * cycle after their pulse.
 */

`timescale 1ns/1ps

module icache_stats (
  input  logic                         clk,
  input  logic                         rstn,
  input  logic                         req_seen,
  input  logic                         hit_seen,
  input  logic                         fill_seen,
  output logic [icache_pkg::CNT_W-1:0] req_count,
  output logic [icache_pkg::CNT_W-1:0] hit_count,
  output logic [icache_pkg::CNT_W-1:0] fill_count
);

  logic [2:0]                          events;
  logic [2:0][icache_pkg::CNT_W-1:0]   counts;

  assign events = {fill_seen, hit_seen, req_seen};

  for (genvar i = 0; i < 3; i++) begin : g_cnt
    always_ff @(posedge clk or negedge rstn) begin
      if (!rstn) begin
        counts[i] <= '0;
      end else if (events[i] && (counts[i] != '1)) begin
        counts[i] <= counts[i] + 1'b1;
      end
    end
  end

  assign req_count  = counts[0];
  assign hit_count  = counts[1];
  assign fill_count = counts[2];

  // A single access either hits or refills, never both at once
  a_hit_xor_fill : assert property (
    @(posedge clk) disable iff (!rstn)
    !(hit_seen && fill_seen)
  ) else $error("icache_stats: hit and fill reported in the same cycle");

endmodule

// ==== design/icache_top.sv ====
/*
 * Direct-mapped, read-only level-1 instruction cache.
 * LINES sets the number of 128-bit lines and must be a power of two.
 * Core side uses a request strobe and a wait level, the next level
 * gets one line-aligned request and returns four words in a row.
 */

`timescale 1ns/1ps

module icache_top #(
  parameter int LINES = 64
) (
  input  logic                         clk,
  input  logic                         rstn,
  input  logic                         core_req,
  input  logic [icache_pkg::ADDR_W-1:0] core_addr,
  output logic                         core_wait,
  output logic [icache_pkg::WORD_W-1:0] core_rdata,
  output logic                         mem_req,
  output logic [icache_pkg::ADDR_W-1:0] mem_addr,
  input  logic                         mem_valid,
  input  logic [icache_pkg::WORD_W-1:0] mem_rdata,
  output logic [icache_pkg::CNT_W-1:0]  req_count,
  output logic [icache_pkg::CNT_W-1:0]  hit_count,
  output logic [icache_pkg::CNT_W-1:0]  fill_count
);

  localparam int INDEX_W = $clog2(LINES);
  localparam int TAG_W   = icache_pkg::ADDR_W - INDEX_W - icache_pkg::OFFSET_W;

  typedef logic [TAG_W-1:0]              tag_t;
  typedef logic [icache_pkg::LINE_W-1:0] line_t;

  logic [INDEX_W-1:0] ram_index;
  logic               tag_re, tag_we, data_re, data_we;
  tag_t               tag_wdata, tag_rdata;
  line_t              data_wdata, data_rdata;
  logic               req_seen, hit_seen, fill_seen;

  icache_ctrl #(.LINES(LINES)) ctrl_i (
    .clk, .rstn,
    .core_req, .core_addr, .core_wait, .core_rdata,
    .mem_req, .mem_addr, .mem_valid, .mem_rdata,
    .ram_index,
    .tag_re, .tag_we, .tag_wdata, .tag_rdata,
    .data_re, .data_we, .data_wdata, .data_rdata,
    .req_seen, .hit_seen, .fill_seen
  );

  icache_sram #(.entry_t(tag_t), .DEPTH(LINES)) tag_ram (
    .clk, .index(ram_index), .re(tag_re), .we(tag_we),
    .wdata(tag_wdata), .rdata(tag_rdata)
  );

  icache_sram #(.entry_t(line_t), .DEPTH(LINES)) data_ram (
    .clk, .index(ram_index), .re(data_re), .we(data_we),
    .wdata(data_wdata), .rdata(data_rdata)
  );

  icache_stats stats_i (
    .clk, .rstn,
    .req_seen, .hit_seen, .fill_seen,
    .req_count, .hit_count, .fill_count
  );

endmodule

// ==== dv/icache_tb.sv ====
/*
 * Directed testbench for the instruction cache.
 * Runs reset, cold miss, line hits, conflict eviction and a seeded
 * random run against a reference tag model, then prints a summary.
 */

`timescale 1ns/1ps

module icache_tb;

  localparam int ADDR_W  = icache_pkg::ADDR_W;
  localparam int WORD_W  = icache_pkg::WORD_W;
  localparam int CNT_W   = icache_pkg::CNT_W;
  localparam int LINES   = 64;
  localparam int MEM_LAT = 3;

  // Run limit from the number of accesses and the worst miss length
  localparam int ACCESSES    = 70;
  localparam int MISS_CYCLES = MEM_LAT + 9;
  localparam int MAX_CYCLES  = 2 * ACCESSES * MISS_CYCLES;

  logic              clk, rstn, core_req, core_wait;
  logic              mem_req, mem_valid;
  logic [ADDR_W-1:0] core_addr, mem_addr;
  logic [WORD_W-1:0] core_rdata, mem_rdata;
  logic [CNT_W-1:0]  req_count, hit_count, fill_count;

  int errors = 0;
  int checks = 0;
  int cycles = 0;
  int exp_req = 0;
  int exp_hit = 0;
  int exp_fill = 0;

  // Reference tag model
  logic              ref_valid [LINES];
  logic [ADDR_W-1:0] ref_tag   [LINES];

  icache_top #(.LINES(LINES)) icache_top_i (
    .clk, .rstn,
    .core_req, .core_addr, .core_wait, .core_rdata,
    .mem_req, .mem_addr, .mem_valid, .mem_rdata,
    .req_count, .hit_count, .fill_count
  );

  icache_tb_mem #(.LATENCY(MEM_LAT)) mem_i (
    .clk, .rstn, .mem_req, .mem_addr, .mem_valid, .mem_rdata
  );

  always #4 clk = ~clk;

  always @(posedge clk) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
      $display("TESTS FAILED");
      $finish;
    end
  end

  // ========================================
  // Reference rules
  // ========================================

  function automatic logic [WORD_W-1:0] expected_word(input logic [ADDR_W-1:0] addr);
    return (addr & ~32'h3) ^ 32'hC0DE0000;
  endfunction

  function automatic int line_index(input logic [ADDR_W-1:0] addr);
    return (addr / 16) % LINES;
  endfunction

  function automatic logic [ADDR_W-1:0] line_tag(input logic [ADDR_W-1:0] addr);
    return addr / (16 * LINES);
  endfunction

  function automatic logic line_hit(input logic [ADDR_W-1:0] addr);
    return ref_valid[line_index(addr)] && (ref_tag[line_index(addr)] == line_tag(addr));
  endfunction

  // ========================================
  // Compare tasks
  // ========================================

  task automatic check_word(input string what, input logic [WORD_W-1:0] got,
                            input logic [WORD_W-1:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERR %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_count(input string what, input logic [CNT_W-1:0] got,
                             input logic [CNT_W-1:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERR %0t: %s is %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic check_bit(input string what, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERR %0t: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  // ========================================
  // Access helpers
  // ========================================

  // Starts and ends 1 ns after a rising edge
  task automatic read_word(input logic [ADDR_W-1:0] addr, output logic [WORD_W-1:0] data,
                           output int waits, output int reqs,
                           output logic [ADDR_W-1:0] req_addr);
    waits = 0;
    reqs = 0;
    req_addr = '0;
    core_req = 1'b1;
    core_addr = addr;
    @(posedge clk);
    #1;
    core_req = 1'b0;
    while (core_wait) begin
      if (mem_req) begin
        reqs++;
        req_addr = mem_addr;
      end
      @(posedge clk);
      #1;
      waits++;
    end
    data = core_rdata;
  endtask

  task automatic do_access(input logic [ADDR_W-1:0] addr);
    logic [WORD_W-1:0] data;
    logic [ADDR_W-1:0] req_addr;
    logic              hit;
    int                waits;
    int                reqs;
    hit = line_hit(addr);
    read_word(addr, data, waits, reqs, req_addr);
    check_word($sformatf("word at %h", addr), data, expected_word(addr));
    exp_req++;
    if (hit) begin
      exp_hit++;
      check_count("mem_req pulses on hit", reqs, 0);
      check_count("wait cycles on hit", waits, 2);
    end else begin
      exp_fill++;
      check_count("mem_req pulses on miss", reqs, 1);
      check_word("mem_addr", req_addr, addr & ~32'hF);
      ref_valid[line_index(addr)] = 1'b1;
      ref_tag[line_index(addr)] = line_tag(addr);
    end
  endtask

  // ========================================
  // Tests
  // ========================================

  task automatic test_reset();
    check_bit("core_wait after reset", core_wait, 1'b0);
    check_bit("mem_req after reset", mem_req, 1'b0);
    check_word("core_rdata after reset", core_rdata, '0);
    check_count("req_count after reset", req_count, 0);
    check_count("hit_count after reset", hit_count, 0);
    check_count("fill_count after reset", fill_count, 0);
  endtask

  task automatic test_cold_miss();
    do_access(32'h0000_1234);
    check_count("fill_count after cold miss", fill_count, 1);
  endtask

  task automatic test_line_hits();
    logic [CNT_W-1:0] hits_before;
    hits_before = exp_hit;
    for (int w = 0; w < icache_pkg::WORDS_PER_LINE; w++) begin
      do_access(32'h0000_1230 + 4 * w);
    end
    check_count("hit_count after line hits", hit_count, hits_before + 4);
  endtask

  // Same index with a tag three cache sizes higher
  task automatic test_conflict();
    logic [CNT_W-1:0] fills_before;
    fills_before = exp_fill;
    do_access(32'h0000_1234 + 3 * LINES * 16);
    do_access(32'h0000_1234);
    check_count("fill_count after eviction", fill_count, fills_before + 2);
  endtask

  // Eight lines over four indices with two tags each
  task automatic test_random();
    int line;
    int word;
    for (int n = 0; n < 60; n++) begin
      line = $urandom_range(0, 7);
      word = $urandom_range(0, 3);
      do_access(32'h0008_0000 + (line % 4) * 16 + (line / 4) * LINES * 16 + word * 4);
    end
    check_count("final req_count", req_count, exp_req);
    check_count("final hit_count", hit_count, exp_hit);
    check_count("final fill_count", fill_count, exp_fill);
  endtask

  initial begin
    clk = 1'b0;
    rstn = 1'b0;
    core_req = 1'b0;
    core_addr = '0;
    $timeformat(-9, 0, " ns", 0);
    for (int i = 0; i < LINES; i++) begin
      ref_valid[i] = 1'b0;
      ref_tag[i] = '0;
    end
    void'($urandom(68));
    repeat (5) @(posedge clk);
    #1;
    rstn = 1'b1;
    @(posedge clk);
    #1;
    test_reset();
    test_cold_miss();
    test_line_hits();
    test_conflict();
    test_random();
    $display("Summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

// ==== dv/icache_tb_mem.sv ====
/*
 * Next-level memory model for the instruction cache testbench.
 * Answers each line request with four consecutive words, offsets
 * 0, 4, 8 and 12. The first word is sampled LATENCY edges after the
 * edge that samples mem_req. The word at byte address A is
 * A ^ 32'hC0DE0000.
 */

`timescale 1ns/1ps

module icache_tb_mem #(
  parameter int LATENCY = 3
) (
  input  logic                          clk,
  input  logic                          rstn,
  input  logic                          mem_req,
  input  logic [icache_pkg::ADDR_W-1:0] mem_addr,
  output logic                          mem_valid,
  output logic [icache_pkg::WORD_W-1:0] mem_rdata
);

  logic [icache_pkg::ADDR_W-1:0] line_addr;

  function automatic logic [icache_pkg::WORD_W-1:0] word_at(
    input logic [icache_pkg::ADDR_W-1:0] addr
  );
    return addr ^ 32'hC0DE0000;
  endfunction

  initial begin
    mem_valid = 1'b0;
    mem_rdata = '0;
    forever begin
      @(posedge clk);
      if (rstn && mem_req) begin
        line_addr = mem_addr;
        repeat (LATENCY - 1) @(posedge clk);
        // Burst of one line, driven just after each edge
        for (int beat = 0; beat < icache_pkg::WORDS_PER_LINE; beat++) begin
          #1;
          mem_valid = 1'b1;
          mem_rdata = word_at(line_addr + icache_pkg::ADDR_W'(4 * beat));
          @(posedge clk);
        end
        #1;
        mem_valid = 1'b0;
        mem_rdata = '0;
      end
    end
  end

endmodule

// ==== verilog.f ====
design/icache_pkg.sv
design/icache_sram.sv
design/icache_ctrl.sv
design/icache_stats.sv
design/icache_top.sv
dv/icache_tb_mem.sv
dv/icache_tb.sv
